// ==== Bender.yml ====
package:
  name: fe_front_end

sources:
  - fe_pkg.sv
  - fe_pc_gen.sv
  - fe_itlb.sv
  - fe_icache.sv
  - fe_top.sv
  - target: test
    files:
      - tb_wb_mem.sv
      - tb_fe_top.sv

// ==== fe_icache.sv ====
// direct-mapped instruction cache
`timescale 1ns/1ps
`default_nettype none

module fe_icache
#(
   parameter int VADDR_WIDTH = 32,
   parameter int PADDR_WIDTH = 24,
   parameter int ICACHE_SETS = 64
)
(
   input  logic                                              clk_i,
   input  logic                                              rst_n_i,
   input  logic [VADDR_WIDTH-1:0]                            fetch_vaddr_i,
   input  logic                                              fetch_v_i,
   input  logic                                              tlb_v_i,
   input  logic [PADDR_WIDTH-fe_pkg::PAGE_OFFSET_WIDTH-1:0]  tlb_ppn_i,
   input  logic                                              tlb_miss_i,
   output logic                                              ic_v_o,
   output logic [fe_pkg::INSTR_WIDTH-1:0]                    ic_instr_o,
   input  logic                                              ic_ready_i,
   input  logic                                              ic_poison_i,
   output logic [PADDR_WIDTH-1:0]                            wb_adr_o,
   output logic                                              wb_cyc_o,
   output logic                                              wb_stb_o,
   input  logic [fe_pkg::INSTR_WIDTH-1:0]                    wb_dat_i,
   input  logic                                              wb_ack_i
);
   import fe_pkg::*;

   localparam int IDX_W = $clog2(ICACHE_SETS);
   // tag covers everything above the word index
   localparam int TAG_W = PADDR_WIDTH - IDX_W - 2;

   logic [INSTR_WIDTH-1:0]       data_mem [ICACHE_SETS];
   logic [TAG_W-1:0]             tag_mem [ICACHE_SETS];
   logic [ICACHE_SETS-1:0]       valid_r;
   icache_state_e                state_r;
   icache_state_e                state_n;
   logic [IDX_W-1:0]             rd_idx;
   logic [INSTR_WIDTH-1:0]       rd_data_r;
   logic [TAG_W-1:0]             rd_tag_r;
   logic                         rd_valid_r;
   logic [PAGE_OFFSET_WIDTH-1:0] off_r;
   logic [PADDR_WIDTH-1:0]       phys_addr;
   logic                         hit;
   logic [PADDR_WIDTH-1:0]       miss_adr_r;
   logic [IDX_W-1:0]             miss_idx;
   logic                         refill_ack;
   logic [INSTR_WIDTH-1:0]       resp_r;

   // index lies inside the page offset, so no translation needed
   assign rd_idx    = fetch_vaddr_i[IDX_W+1:2];
   assign phys_addr = {tlb_ppn_i, off_r};
   assign hit       = tlb_v_i && !tlb_miss_i && rd_valid_r
                      && (rd_tag_r == phys_addr[PADDR_WIDTH-1:IDX_W+2]);
   assign miss_idx   = miss_adr_r[IDX_W+1:2];
   assign refill_ack = (state_r == e_ic_refill) && wb_ack_i;

   assign ic_v_o     = (state_r == e_ic_respond);
   assign ic_instr_o = resp_r;
   assign wb_adr_o   = miss_adr_r;
   assign wb_cyc_o   = (state_r == e_ic_refill);
   assign wb_stb_o   = (state_r == e_ic_refill);

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_ic_idle:
         begin
            if (fetch_v_i)
               state_n = e_ic_lookup;
         end
         e_ic_lookup:
         begin
            if (!tlb_v_i || tlb_miss_i)
               state_n = e_ic_idle;
            else if (hit)
               state_n = e_ic_respond;
            else
               state_n = e_ic_refill;
         end
         e_ic_refill:
         begin
            if (wb_ack_i)
               state_n = e_ic_respond;
         end
         e_ic_respond:
         begin
            if (ic_ready_i || ic_poison_i)
               state_n = e_ic_idle;
         end
         default:
            state_n = e_ic_idle;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_r <= e_ic_idle;
         valid_r <= '0;
      end
      else
      begin
         state_r <= state_n;
         if (refill_ack)
            valid_r[miss_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      // array read in the fetch cycle
      if ((state_r == e_ic_idle) && fetch_v_i)
      begin
         rd_data_r  <= data_mem[rd_idx];
         rd_tag_r   <= tag_mem[rd_idx];
         rd_valid_r <= valid_r[rd_idx];
         off_r      <= fetch_vaddr_i[PAGE_OFFSET_WIDTH-1:0];
      end
      if (state_r == e_ic_lookup)
      begin
         miss_adr_r <= {phys_addr[PADDR_WIDTH-1:2], 2'b00};
         resp_r     <= rd_data_r;
      end
      if (refill_ack)
      begin
         data_mem[miss_idx] <= wb_dat_i;
         tag_mem[miss_idx]  <= miss_adr_r[PADDR_WIDTH-1:IDX_W+2];
         resp_r             <= wb_dat_i;
      end
   end

endmodule

`default_nettype wire

// ==== fe_itlb.sv ====
// instruction tlb
`timescale 1ns/1ps
`default_nettype none

module fe_itlb
#(
   parameter int VADDR_WIDTH  = 32,
   parameter int PADDR_WIDTH  = 24,
   parameter int ITLB_ENTRIES = 8
)
(
   input  logic                                              clk_i,
   input  logic                                              rst_n_i,
   input  logic [VADDR_WIDTH-1:0]                            fetch_vaddr_i,
   input  logic                                              fetch_v_i,
   input  fe_pkg::fe_cmd_op_e                                fe_cmd_op_i,
   input  logic [VADDR_WIDTH-1:0]                            fe_cmd_pc_i,
   input  logic [PADDR_WIDTH-fe_pkg::PAGE_OFFSET_WIDTH-1:0]  fe_cmd_ppn_i,
   input  logic                                              fe_cmd_v_i,
   output logic                                              tlb_v_o,
   output logic [PADDR_WIDTH-fe_pkg::PAGE_OFFSET_WIDTH-1:0]  tlb_ppn_o,
   output logic                                              tlb_miss_o
);
   import fe_pkg::*;

   localparam int VTAG_W = VADDR_WIDTH - PAGE_OFFSET_WIDTH;
   localparam int PTAG_W = PADDR_WIDTH - PAGE_OFFSET_WIDTH;
   localparam int IDX_W  = $clog2(ITLB_ENTRIES);

   logic [VTAG_W-1:0]       vtag_mem [ITLB_ENTRIES];
   logic [PTAG_W-1:0]       ppn_mem [ITLB_ENTRIES];
   logic [ITLB_ENTRIES-1:0] valid_r;
   logic [IDX_W-1:0]        rr_r;
   logic                    rd_hit;
   logic [IDX_W-1:0]        rd_idx;
   logic                    wr_hit;
   logic [IDX_W-1:0]        wr_idx;
   logic [IDX_W-1:0]        fill_idx;
   logic                    fill_v;

   // returns {hit, index} of a valid entry holding tag
   function automatic logic [IDX_W:0] find_tag(input logic [VTAG_W-1:0] tag);
      logic [IDX_W:0] res;
      res = '0;
      for (int i = 0; i < ITLB_ENTRIES; i++)
      begin
         if (valid_r[i] && (vtag_mem[i] == tag))
            res = {1'b1, IDX_W'(i)};
      end
      return res;
   endfunction

   assign {rd_hit, rd_idx} = find_tag(fetch_vaddr_i[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH]);
   assign {wr_hit, wr_idx} = find_tag(fe_cmd_pc_i[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH]);

   assign fill_v   = fe_cmd_v_i && (fe_cmd_op_i == e_op_itlb_fill);
   // refill of a known page keeps its slot
   assign fill_idx = wr_hit ? wr_idx : rr_r;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         valid_r    <= '0;
         rr_r       <= '0;
         tlb_v_o    <= 1'b0;
         tlb_miss_o <= 1'b0;
      end
      else
      begin
         tlb_v_o    <= fetch_v_i;
         tlb_miss_o <= fetch_v_i && !rd_hit;
         if (fill_v)
         begin
            valid_r[fill_idx] <= 1'b1;
            if (!wr_hit)
               rr_r <= rr_r + IDX_W'(1);
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (fill_v)
      begin
         vtag_mem[fill_idx] <= fe_cmd_pc_i[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH];
         ppn_mem[fill_idx]  <= fe_cmd_ppn_i;
      end
      if (fetch_v_i)
         tlb_ppn_o <= ppn_mem[rd_idx];
   end

endmodule

`default_nettype wire

// ==== fe_pc_gen.sv ====
// fetch pc generator
`timescale 1ns/1ps
`default_nettype none

module fe_pc_gen
#(
   parameter int VADDR_WIDTH = 32
)
(
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  fe_pkg::fe_cmd_op_e             fe_cmd_op_i,
   input  logic [VADDR_WIDTH-1:0]         fe_cmd_pc_i,
   input  logic                           fe_cmd_v_i,
   output logic                           fe_cmd_ready_o,
   output logic [VADDR_WIDTH-1:0]         fetch_vaddr_o,
   output logic                           fetch_v_o,
   input  logic                           tlb_v_i,
   input  logic                           tlb_miss_i,
   input  logic                           ic_v_i,
   input  logic [fe_pkg::INSTR_WIDTH-1:0] ic_instr_i,
   output logic                           ic_ready_o,
   output logic                           ic_poison_o,
   output logic [VADDR_WIDTH-1:0]         fe_queue_pc_o,
   output logic [fe_pkg::INSTR_WIDTH-1:0] fe_queue_instr_o,
   output fe_pkg::fe_msg_e                fe_queue_msg_o,
   output logic                           fe_queue_v_o,
   input  logic                           fe_queue_ready_i
);
   import fe_pkg::*;

   pc_gen_state_e          state_r;
   pc_gen_state_e          state_n;
   logic [VADDR_WIDTH-1:0] pc_r;
   logic [VADDR_WIDTH-1:0] pc_n;
   logic                   poison_r;
   logic                   poison_n;
   logic                   ready_r;
   logic                   cmd_acc;
   logic                   cmd_reset;
   logic                   cmd_jump;
   logic                   cmd_fill;
   logic                   tlb_fault;
   logic                   fetch_done;
   logic                   stale;
   logic [INSTR_WIDTH-1:0] q_instr_r;
   fe_msg_e                q_msg_r;

   assign cmd_acc    = fe_cmd_v_i && ready_r;
   assign cmd_reset  = cmd_acc && (fe_cmd_op_i == e_op_state_reset);
   assign cmd_jump   = cmd_reset || (cmd_acc && (fe_cmd_op_i == e_op_pc_redirect));
   assign cmd_fill   = cmd_acc && (fe_cmd_op_i == e_op_itlb_fill);
   assign tlb_fault  = tlb_v_i && tlb_miss_i;
   // cache drops the lookup on a tlb miss, so that ends the fetch too
   assign fetch_done = ic_v_i || tlb_fault;
   assign stale      = poison_r || cmd_jump;

   assign fe_cmd_ready_o   = ready_r;
   assign fetch_vaddr_o    = pc_r;
   assign fetch_v_o        = (state_r == e_pg_issue);
   assign ic_ready_o       = (state_r == e_pg_wait) && !stale;
   assign ic_poison_o      = (state_r == e_pg_wait) && stale;
   assign fe_queue_pc_o    = pc_r;
   assign fe_queue_instr_o = q_instr_r;
   assign fe_queue_msg_o   = q_msg_r;
   assign fe_queue_v_o     = (state_r == e_pg_out);

   always_comb
   begin
      state_n  = state_r;
      pc_n     = pc_r;
      poison_n = poison_r;
      case (state_r)
         e_pg_halt:
         begin
            if (cmd_reset)
            begin
               pc_n    = fe_cmd_pc_i;
               state_n = e_pg_issue;
            end
         end
         e_pg_issue:
         begin
            state_n = e_pg_wait;
            // the issued fetch is already gone
            if (cmd_jump)
            begin
               pc_n     = fe_cmd_pc_i;
               poison_n = 1'b1;
            end
         end
         e_pg_wait:
         begin
            if (cmd_jump)
               pc_n = fe_cmd_pc_i;
            if (fetch_done)
            begin
               poison_n = 1'b0;
               state_n  = stale ? e_pg_issue : e_pg_out;
            end
            else if (cmd_jump)
               poison_n = 1'b1;
         end
         e_pg_out:
         begin
            if (cmd_jump)
            begin
               pc_n    = fe_cmd_pc_i;
               state_n = e_pg_issue;
            end
            else if (fe_queue_ready_i)
            begin
               if (q_msg_r == e_msg_fetch)
               begin
                  pc_n    = pc_r + VADDR_WIDTH'(4);
                  state_n = e_pg_issue;
               end
               else
                  state_n = e_pg_miss;
            end
         end
         e_pg_miss:
         begin
            if (cmd_jump)
            begin
               pc_n    = fe_cmd_pc_i;
               state_n = e_pg_issue;
            end
            // retry the pc that missed
            else if (cmd_fill)
               state_n = e_pg_issue;
         end
         default:
            state_n = e_pg_halt;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_r  <= e_pg_halt;
         pc_r     <= '0;
         poison_r <= 1'b0;
         ready_r  <= 1'b0;
      end
      else
      begin
         state_r  <= state_n;
         pc_r     <= pc_n;
         poison_r <= poison_n;
         ready_r  <= 1'b1;
      end
   end

   // queue entry
   always_ff @(posedge clk_i)
   begin
      if ((state_r == e_pg_wait) && fetch_done && !stale)
      begin
         q_instr_r <= tlb_fault ? '0 : ic_instr_i;
         q_msg_r   <= tlb_fault ? e_msg_itlb_miss : e_msg_fetch;
      end
   end

endmodule

`default_nettype wire

// ==== fe_pkg.sv ====
// front end shared types
`default_nettype none

package fe_pkg;

   // 4 KiB pages
   localparam int PAGE_OFFSET_WIDTH = 12;
   localparam int INSTR_WIDTH = 32;

   // back end command opcodes
   typedef enum logic [1:0]
   {
      e_op_state_reset,
      e_op_pc_redirect,
      e_op_itlb_fill
   } fe_cmd_op_e;

   // fetch queue message type
   typedef enum logic
   {
      e_msg_fetch,
      e_msg_itlb_miss
   } fe_msg_e;

   typedef enum logic [1:0]
   {
      e_ic_idle,
      e_ic_lookup,
      e_ic_refill,
      e_ic_respond
   } icache_state_e;

   typedef enum logic [2:0]
   {
      e_pg_halt,
      e_pg_issue,
      e_pg_wait,
      e_pg_miss,
      e_pg_out
   } pc_gen_state_e;

endpackage

`default_nettype wire

// ==== fe_top.sv ====
// instruction fetch front end
`timescale 1ns/1ps
`default_nettype none

module fe_top
#(
   parameter int VADDR_WIDTH  = 32,
   parameter int PADDR_WIDTH  = 24,
   parameter int ITLB_ENTRIES = 8,
   parameter int ICACHE_SETS  = 64
)
(
   input  logic                                              clk_i,
   input  logic                                              rst_n_i,
   input  fe_pkg::fe_cmd_op_e                                fe_cmd_op_i,
   input  logic [VADDR_WIDTH-1:0]                            fe_cmd_pc_i,
   input  logic [PADDR_WIDTH-fe_pkg::PAGE_OFFSET_WIDTH-1:0]  fe_cmd_ppn_i,
   input  logic                                              fe_cmd_v_i,
   output logic                                              fe_cmd_ready_o,
   output logic [VADDR_WIDTH-1:0]                            fe_queue_pc_o,
   output logic [fe_pkg::INSTR_WIDTH-1:0]                    fe_queue_instr_o,
   output fe_pkg::fe_msg_e                                   fe_queue_msg_o,
   output logic                                              fe_queue_v_o,
   input  logic                                              fe_queue_ready_i,
   output logic [PADDR_WIDTH-1:0]                            wb_adr_o,
   output logic                                              wb_cyc_o,
   output logic                                              wb_stb_o,
   input  logic [fe_pkg::INSTR_WIDTH-1:0]                    wb_dat_i,
   input  logic                                              wb_ack_i
);
   import fe_pkg::*;

   logic [VADDR_WIDTH-1:0]                   fetch_vaddr;
   logic                                     fetch_v;
   logic                                     tlb_v;
   logic [PADDR_WIDTH-PAGE_OFFSET_WIDTH-1:0] tlb_ppn;
   logic                                     tlb_miss;
   logic                                     ic_v;
   logic [INSTR_WIDTH-1:0]                   ic_instr;
   logic                                     ic_ready;
   logic                                     ic_poison;

   fe_pc_gen
   #(
      .VADDR_WIDTH (VADDR_WIDTH)
   )
   u_pc_gen
   (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .fe_cmd_op_i      (fe_cmd_op_i),
      .fe_cmd_pc_i      (fe_cmd_pc_i),
      .fe_cmd_v_i       (fe_cmd_v_i),
      .fe_cmd_ready_o   (fe_cmd_ready_o),
      .fetch_vaddr_o    (fetch_vaddr),
      .fetch_v_o        (fetch_v),
      .tlb_v_i          (tlb_v),
      .tlb_miss_i       (tlb_miss),
      .ic_v_i           (ic_v),
      .ic_instr_i       (ic_instr),
      .ic_ready_o       (ic_ready),
      .ic_poison_o      (ic_poison),
      .fe_queue_pc_o    (fe_queue_pc_o),
      .fe_queue_instr_o (fe_queue_instr_o),
      .fe_queue_msg_o   (fe_queue_msg_o),
      .fe_queue_v_o     (fe_queue_v_o),
      .fe_queue_ready_i (fe_queue_ready_i)
   );

   fe_itlb
   #(
      .VADDR_WIDTH  (VADDR_WIDTH),
      .PADDR_WIDTH  (PADDR_WIDTH),
      .ITLB_ENTRIES (ITLB_ENTRIES)
   )
   u_itlb
   (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .fetch_vaddr_i (fetch_vaddr),
      .fetch_v_i     (fetch_v),
      .fe_cmd_op_i   (fe_cmd_op_i),
      .fe_cmd_pc_i   (fe_cmd_pc_i),
      .fe_cmd_ppn_i  (fe_cmd_ppn_i),
      .fe_cmd_v_i    (fe_cmd_v_i),
      .tlb_v_o       (tlb_v),
      .tlb_ppn_o     (tlb_ppn),
      .tlb_miss_o    (tlb_miss)
   );

   fe_icache
   #(
      .VADDR_WIDTH (VADDR_WIDTH),
      .PADDR_WIDTH (PADDR_WIDTH),
      .ICACHE_SETS (ICACHE_SETS)
   )
   u_icache
   (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .fetch_vaddr_i (fetch_vaddr),
      .fetch_v_i     (fetch_v),
      .tlb_v_i       (tlb_v),
      .tlb_ppn_i     (tlb_ppn),
      .tlb_miss_i    (tlb_miss),
      .ic_v_o        (ic_v),
      .ic_instr_o    (ic_instr),
      .ic_ready_i    (ic_ready),
      .ic_poison_i   (ic_poison),
      .wb_adr_o      (wb_adr_o),
      .wb_cyc_o      (wb_cyc_o),
      .wb_stb_o      (wb_stb_o),
      .wb_dat_i      (wb_dat_i),
      .wb_ack_i      (wb_ack_i)
   );

endmodule

`default_nettype wire

// ==== project.f ====
fe_pkg.sv
fe_pc_gen.sv
fe_itlb.sv
fe_icache.sv
fe_top.sv
tb_wb_mem.sv
tb_fe_top.sv

// ==== tb_fe_top.sv ====
// front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_fe_top;
   import fe_pkg::*;

   localparam int VW      = 32;
   localparam int PW      = 24;
   localparam int TIMEOUT = 2000;

   logic          clk;
   logic          rst_n;
   fe_cmd_op_e    fe_cmd_op;
   logic [VW-1:0] fe_cmd_pc;
   logic [11:0]   fe_cmd_ppn;
   logic          fe_cmd_v;
   logic          fe_cmd_ready_o;
   logic [VW-1:0] fe_queue_pc_o;
   logic [31:0]   fe_queue_instr_o;
   fe_msg_e       fe_queue_msg_o;
   logic          fe_queue_v_o;
   logic          q_ready;
   logic [PW-1:0] wb_adr_o;
   logic          wb_cyc_o;
   logic          wb_stb_o;
   logic [31:0]   wb_dat;
   logic          wb_ack;
   logic [1:0]    mem_delay;

   // scoreboard state
   string         test_name;
   int            ready_mode;
   logic [31:0]   rng = 32'd81716;
   logic [11:0]   page_map [logic [19:0]];
   logic [PW-1:0] resident_line [64];
   logic [63:0]   resident_v;
   logic [VW-1:0] exp_pc;
   logic [VW-1:0] prev_pc;
   logic [VW-1:0] first_pc;
   logic [31:0]   first_instr;
   logic          first_pending;
   logic          jump_acc;
   logic          fill_acc;
   logic          cyc_seen;
   int            xfer_count;
   int            miss_count;
   int            refill_count;
   int            snap;
   logic [31:0]   instr_a;

   fe_top DUT
   (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .fe_cmd_op_i      (fe_cmd_op),
      .fe_cmd_pc_i      (fe_cmd_pc),
      .fe_cmd_ppn_i     (fe_cmd_ppn),
      .fe_cmd_v_i       (fe_cmd_v),
      .fe_cmd_ready_o   (fe_cmd_ready_o),
      .fe_queue_pc_o    (fe_queue_pc_o),
      .fe_queue_instr_o (fe_queue_instr_o),
      .fe_queue_msg_o   (fe_queue_msg_o),
      .fe_queue_v_o     (fe_queue_v_o),
      .fe_queue_ready_i (q_ready),
      .wb_adr_o         (wb_adr_o),
      .wb_cyc_o         (wb_cyc_o),
      .wb_stb_o         (wb_stb_o),
      .wb_dat_i         (wb_dat),
      .wb_ack_i         (wb_ack)
   );

   tb_wb_mem #(.ADDR_WIDTH (PW)) u_mem
   (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .wb_adr_i (wb_adr_o),
      .wb_cyc_i (wb_cyc_o),
      .wb_stb_i (wb_stb_o),
      .wb_dat_o (wb_dat),
      .wb_ack_o (wb_ack),
      .delay_i  (mem_delay)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [PW-1:0] phys_of(input logic [VW-1:0] pc);
      logic [11:0] ppn;
      ppn = page_map.exists(pc[31:12]) ? page_map[pc[31:12]] : 12'h000;
      return {ppn, pc[11:0]};
   endfunction

   task automatic fail_run(input string what);
      $display("%s: %s", test_name, what);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act)
      else
      begin
         $display("error %s/%s expected %h actual %h", test_name, name, exp, act);
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   endtask

   // ready pattern and ack delays
   always @(posedge clk)
   begin
      rng = xorshift32(rng);
      mem_delay <= rng[5:4];
      if (ready_mode == 2)
         q_ready <= rng[9] | rng[12];
      else
         q_ready <= (ready_mode == 1);
   end

   // queue and wishbone monitor on the falling edge
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         jump_acc = fe_cmd_v && fe_cmd_ready_o && (fe_cmd_op != e_op_itlb_fill);
         fill_acc = fe_cmd_v && fe_cmd_ready_o && (fe_cmd_op == e_op_itlb_fill);
         if (fe_queue_v_o && q_ready && !jump_acc)
         begin
            expect_eq("queue pc", exp_pc, fe_queue_pc_o);
            if (page_map.exists(exp_pc[31:12]))
            begin
               expect_eq("queue msg", 32'(e_msg_fetch), 32'(fe_queue_msg_o));
               expect_eq("queue instr", {8'hA5, phys_of(exp_pc)}, fe_queue_instr_o);
               exp_pc = exp_pc + 32'd4;
            end
            else
            begin
               expect_eq("queue msg", 32'(e_msg_itlb_miss), 32'(fe_queue_msg_o));
               miss_count++;
            end
            if (first_pending)
            begin
               first_pc      = fe_queue_pc_o;
               first_instr   = fe_queue_instr_o;
               first_pending = 1'b0;
            end
            xfer_count++;
         end
         if (wb_cyc_o && !cyc_seen)
         begin
            assert (!(resident_v[wb_adr_o[7:2]] && resident_line[wb_adr_o[7:2]] == wb_adr_o))
            else
               fail_run("wishbone refill of a line already in the cache");
            assert (wb_adr_o == phys_of(exp_pc) || wb_adr_o == phys_of(prev_pc))
            else
               fail_run("wishbone address is not the current miss");
            resident_line[wb_adr_o[7:2]] = wb_adr_o;
            resident_v[wb_adr_o[7:2]]    = 1'b1;
            refill_count++;
         end
         cyc_seen = wb_cyc_o;
         if (jump_acc)
         begin
            prev_pc       = exp_pc;
            exp_pc        = fe_cmd_pc;
            first_pending = 1'b1;
         end
         if (fill_acc)
            page_map[fe_cmd_pc[31:12]] = fe_cmd_ppn;
      end
   end

   held_entry: assert property (@(posedge clk) disable iff (!rst_n)
      (fe_queue_v_o && !q_ready && !(fe_cmd_v && fe_cmd_op != e_op_itlb_fill))
      |=> (fe_queue_v_o && $stable(fe_queue_pc_o) && $stable(fe_queue_instr_o)
           && $stable(fe_queue_msg_o)))
   else
      fail_run("queue entry changed before it transferred");

   wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_cyc_o && !wb_ack) |=> (wb_cyc_o && $stable(wb_adr_o)))
   else
      fail_run("wishbone cycle dropped or address moved before ack");

   wb_end: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |=> !wb_cyc_o)
   else
      fail_run("wishbone cycle still open after ack");

   wb_strobe: assert property (@(posedge clk) disable iff (!rst_n) wb_cyc_o == wb_stb_o)
   else
      fail_run("wishbone cyc and stb differ");

   task automatic send_cmd(input fe_cmd_op_e op, input logic [VW-1:0] pc, input logic [11:0] ppn);
      int  n;
      logic done;
      done = 1'b0;
      @(posedge clk);
      fe_cmd_op  <= op;
      fe_cmd_pc  <= pc;
      fe_cmd_ppn <= ppn;
      fe_cmd_v   <= 1'b1;
      for (n = 0; n < TIMEOUT && !done; n++)
      begin
         @(negedge clk);
         done = fe_cmd_ready_o;
      end
      if (!done)
         fail_run("command was never accepted");
      @(posedge clk);
      fe_cmd_v <= 1'b0;
   endtask

   task automatic wait_entries(input int count);
      int target;
      int n;
      target = xfer_count + count;
      for (n = 0; n < TIMEOUT && xfer_count < target; n++)
         @(posedge clk);
      if (xfer_count < target)
         fail_run("timed out waiting for fetch queue entries");
   endtask

   task automatic wait_wb_busy();
      int n;
      for (n = 0; n < TIMEOUT && !wb_cyc_o; n++)
         @(negedge clk);
      if (!wb_cyc_o)
         fail_run("timed out waiting for a wishbone cycle");
   endtask

   initial
   begin
      rst_n = 1'b0;
      fe_cmd_op = e_op_state_reset;
      fe_cmd_pc = '0;
      fe_cmd_ppn = '0;
      fe_cmd_v = 1'b0;
      q_ready = 1'b0;
      ready_mode = 1;
      resident_v = '0;
      exp_pc = '0;
      prev_pc = '0;
      first_pending = 1'b0;
      cyc_seen = 1'b0;
      xfer_count = 0;
      miss_count = 0;
      refill_count = 0;
      test_name = "reset";
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      assert (!fe_queue_v_o && !wb_cyc_o)
      else
         fail_run("queue valid or wishbone cycle high after reset");

      // unmapped page gives a miss message
      send_cmd(e_op_state_reset, 32'h0000_1000, 12'h000);
      wait_entries(1);
      expect_eq("miss count", 32'd1, miss_count);

      test_name = "fill stream";
      send_cmd(e_op_itlb_fill, 32'h0000_1000, 12'h123);
      wait_entries(20);

      test_name = "redirect hit";
      send_cmd(e_op_pc_redirect, 32'h0000_1000, 12'h000);
      wait_entries(1);
      snap = refill_count;
      wait_entries(8);
      expect_eq("refills on hits", snap, refill_count);

      test_name = "redirect in flight";
      send_cmd(e_op_itlb_fill, 32'h0000_5000, 12'h0AB);
      send_cmd(e_op_pc_redirect, 32'h0000_1100, 12'h000);
      wait_wb_busy();
      send_cmd(e_op_pc_redirect, 32'h0000_5000, 12'h000);
      wait_entries(6);
      expect_eq("first pc", 32'h0000_5000, first_pc);

      test_name = "back-pressure";
      ready_mode = 2;
      wait_entries(60);
      ready_mode = 1;

      // same cache index but a different physical page
      test_name = "physical tag";
      send_cmd(e_op_itlb_fill, 32'h0000_7000, 12'h0CD);
      send_cmd(e_op_pc_redirect, 32'h0000_7000, 12'h000);
      wait_entries(4);
      instr_a = first_instr;
      expect_eq("page 7 instr", 32'hA50CD000, instr_a);
      send_cmd(e_op_pc_redirect, 32'h0000_5000, 12'h000);
      wait_entries(4);
      expect_eq("page 5 instr", 32'hA50AB000, first_instr);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_wb_mem.sv ====
// wishbone memory model
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem
#(
   parameter int ADDR_WIDTH = 24
)
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic [ADDR_WIDTH-1:0] wb_adr_i,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   output logic [31:0]           wb_dat_o,
   output logic                  wb_ack_o,
   input  logic [1:0]            delay_i
);

   logic [1:0] wait_cnt_r;

   // data is a marker byte over the byte address
   assign wb_dat_o = {8'hA5, wb_adr_i};

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wb_ack_o   <= 1'b0;
         wait_cnt_r <= '0;
      end
      else if (wb_cyc_i && wb_stb_i && !wb_ack_o)
      begin
         if (wait_cnt_r >= delay_i)
         begin
            wb_ack_o   <= 1'b1;
            wait_cnt_r <= '0;
         end
         else
            wait_cnt_r <= wait_cnt_r + 2'd1;
      end
      else
      begin
         wb_ack_o <= 1'b0;
         if (!wb_cyc_i)
            wait_cnt_r <= '0;
      end
   end

endmodule

`default_nettype wire
